/* compile.f */
+incdir+design
design/fetch_pkg.sv
design/fetch_stream_if.sv
design/fetch_request_ctrl.sv
design/fetch_fifo.sv
design/fetch_out_skid.sv
design/prefetch_top.sv
bench/instr_mem_model.sv
bench/prefetch_tb.sv

/* Makefile */
# Verilator build and run of the prefetch unit testbench

VERILATOR ?= verilator
TOP       ?= prefetch_tb
SRCS      ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP SRCS BUILD_DIR VFLAGS"

# the run passes only when the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(SRCS) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)

/* bench/prefetch_testdata.txt */
// columns in hex: branch target, instructions to accept, ready probability in percent
// probability 0 stalls the core first, then accepts at full rate; count 0 ends the list
00001000 00000010 00000064
00001002 00000008 00000032
00002000 0000000C 00000019
00002001 00000005 0000004B
00003000 00000001 00000064
00003004 00000001 00000064
00003008 00000003 0000000A
00004000 00000006 00000000
00000000 00000014 0000005A
FFFFFFF8 00000006 00000064
0000ABC3 00000009 00000032
00010000 00000002 00000064
00010010 00000002 00000019
20000000 00000010 0000004B
20000040 00000004 00000000
12345678 0000000A 00000050
1234567B 00000007 00000028
00005000 00000003 00000064
00005000 00000003 00000064
7FFFFFFC 00000005 00000032
80000002 00000008 00000014
00000100 00000018 0000003C
00000200 00000001 00000005
00000300 0000000C 00000064
00000400 00000006 00000000
00000404 00000004 00000064
00000000 00000000 00000000

/* bench/prefetch_tb.sv */
//////////////////////////////
// prefetch unit testbench
// branch scenarios from a data file, random core ready
//////////////////////////////

`timescale 1ns/1ns

`include "fetch_consts.svh"

module prefetch_tb;

  localparam int ClkPeriod   = 20;
  localparam int ResetCycles = 5;
  localparam int StallCycles = 40;
  localparam int WaitLimit   = 300;
  localparam int MaxWords    = 192;
  localparam int RandSeed    = 48010;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     req;
  logic                     branch;
  logic [`FETCH_ADDR_W-1:0] branch_addr;
  logic                     core_ready;
  logic                     valid;
  logic [`FETCH_DATA_W-1:0] rdata;
  logic [`FETCH_ADDR_W-1:0] addr;
  logic                     instr_req;
  logic                     instr_gnt;
  logic [`FETCH_ADDR_W-1:0] instr_addr;
  logic [`FETCH_DATA_W-1:0] instr_rdata;
  logic                     instr_rvalid;
  logic                     busy;

  // scenario table with three words per line
  logic [31:0]              testdata [MaxWords];

  integer                   seed;
  int                       errors;
  int                       timeouts;
  int                       accepted;
  logic                     fetch_on;
  // address the next accepted instruction must have
  logic [`FETCH_ADDR_W-1:0] exp_addr;
  // payload seen in a stalled cycle
  logic                     hold_pending;
  logic [`FETCH_ADDR_W-1:0] held_addr;
  logic [`FETCH_DATA_W-1:0] held_rdata;
  // memory request seen waiting for its grant
  logic                     req_waiting;
  logic [`FETCH_ADDR_W-1:0] waiting_addr;

  prefetch_top prefetch_top_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req),
    .branch_i      (branch),
    .addr_i        (branch_addr),
    .ready_i       (core_ready),
    .valid_o       (valid),
    .rdata_o       (rdata),
    .addr_o        (addr),
    .instr_req_o   (instr_req),
    .instr_gnt_i   (instr_gnt),
    .instr_addr_o  (instr_addr),
    .instr_rdata_i (instr_rdata),
    .instr_rvalid_i(instr_rvalid),
    .busy_o        (busy)
  );

  instr_mem_model #(.Seed(RandSeed)) mem_model_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (instr_req),
    .addr_i  (instr_addr),
    .gnt_o   (instr_gnt),
    .rdata_o (instr_rdata),
    .rvalid_o(instr_rvalid)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  //////////////////////////////
  // reference rules
  //////////////////////////////

  // memory word is the address rotated left by 8 with the upper half xor A5A5
  function automatic logic [`FETCH_DATA_W-1:0] expected_word(
    input logic [`FETCH_ADDR_W-1:0] a
  );
    return {a[23:0], a[31:24]} ^ 32'hA5A5_0000;
  endfunction

  // successor is the address rounded down to a multiple of 4 plus one word
  function automatic logic [`FETCH_ADDR_W-1:0] next_word_addr(
    input logic [`FETCH_ADDR_W-1:0] a
  );
    return (a & ~32'h3) + 32'd4;
  endfunction

  task automatic check_flag(input string name, input logic expected, input logic actual);
    assert (actual === expected) else begin
      errors++;
      $display("Error: %s expected %h got %h", name, expected, actual);
    end
  endtask

  task automatic compare_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("Error: %s expected %h got %h", name, expected, actual);
    end
  endtask

  //////////////////////////////
  // cycle driver and monitor
  //////////////////////////////

  // mid-cycle look at the core side since a handshake completes at the next edge
  task automatic sample_outputs();
    // a request without grant keeps its address unless a branch retargets it
    if (req_waiting && !branch) begin
      check_flag("instr_req_o", 1'b1, instr_req);
      compare_word("instr_addr_o", waiting_addr, instr_addr);
    end
    req_waiting  = instr_req && !instr_gnt;
    waiting_addr = instr_addr;
    if (hold_pending && !branch) begin
      check_flag("valid_o", 1'b1, valid);
      compare_word("addr_o", held_addr, addr);
      compare_word("rdata_o", held_rdata, rdata);
    end
    hold_pending = 1'b0;
    if (valid && !branch) begin
      if (core_ready) begin
        compare_word("addr_o", exp_addr, addr);
        compare_word("rdata_o", expected_word(exp_addr), rdata);
        exp_addr = next_word_addr(exp_addr);
        accepted++;
      end else begin
        hold_pending = 1'b1;
        held_addr    = addr;
        held_rdata   = rdata;
      end
    end
  endtask

  // inputs change right after the rising edge and outputs are read at the falling edge
  task automatic drive_cycle(input logic rdy, input logic br, input logic [31:0] target);
    @(posedge clk_i);
    req        <= fetch_on;
    core_ready <= rdy;
    branch     <= br;
    if (br) begin
      branch_addr <= target;
    end
    @(negedge clk_i);
    sample_outputs();
  endtask

  // one branch cycle with the core not ready so nothing of the old stream is taken
  task automatic pulse_branch(input logic [31:0] target);
    exp_addr = target;
    drive_cycle(1'b0, 1'b1, target);
  endtask

  task automatic accept_words(input int count, input int pct);
    int   idle;
    int   prev;
    int   roll;
    logic rdy;
    idle     = 0;
    accepted = 0;
    while (accepted < count && idle < WaitLimit) begin
      roll = int'($unsigned($random(seed)) % 100);
      rdy  = (roll < pct);
      prev = accepted;
      drive_cycle(rdy, 1'b0, '0);
      idle = (accepted == prev) ? idle + 1 : 0;
    end
    if (accepted < count) begin
      timeouts++;
      $display("Timeout: only %0d of %0d instructions arrived after the branch",
               accepted, count);
    end
  endtask

  // core holds ready low and fetching must stop once the buffers are full
  task automatic stall_until_idle();
    int n;
    int waited;
    for (n = 0; n < StallCycles; n++) begin
      drive_cycle(1'b0, 1'b0, '0);
    end
    check_flag("valid_o", 1'b1, valid);
    waited = 0;
    while ((instr_req || busy) && waited < WaitLimit) begin
      drive_cycle(1'b0, 1'b0, '0);
      waited++;
    end
    if (instr_req || busy) begin
      timeouts++;
      $display("Timeout: memory requests did not stop while the core stalled");
    end else begin
      for (n = 0; n < 5; n++) begin
        drive_cycle(1'b0, 1'b0, '0);
        check_flag("instr_req_o", 1'b0, instr_req);
        check_flag("busy_o", 1'b0, busy);
      end
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int          idx;
    int          line;
    int          count;
    int          pct;
    int          gap;
    logic [31:0] target;
    seed         = RandSeed;
    errors       = 0;
    timeouts     = 0;
    accepted     = 0;
    fetch_on     = 1'b0;
    hold_pending = 1'b0;
    exp_addr     = '0;
    held_addr    = '0;
    held_rdata   = '0;
    req_waiting  = 1'b0;
    waiting_addr = '0;
    rst_ni      <= 1'b0;
    req         <= 1'b0;
    branch      <= 1'b0;
    branch_addr <= '0;
    core_ready  <= 1'b0;
    for (idx = 0; idx < MaxWords; idx++) begin
      testdata[idx] = '0;
    end
    $readmemh("bench/prefetch_testdata.txt", testdata);

    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;

    // idle after reset with no request yet
    repeat (3) begin
      drive_cycle(1'b0, 1'b0, '0);
      check_flag("valid_o", 1'b0, valid);
      check_flag("instr_req_o", 1'b0, instr_req);
      check_flag("busy_o", 1'b0, busy);
    end
    fetch_on = 1'b1;

    line = 0;
    while (line < MaxWords / 3 && testdata[3 * line + 1] != 0 && timeouts == 0) begin
      target = testdata[3 * line];
      count  = int'(testdata[3 * line + 1]);
      pct    = int'(testdata[3 * line + 2]);
      pulse_branch(target);
      if (pct == 0) begin
        stall_until_idle();
        pct = 100;
      end
      if (timeouts == 0) begin
        accept_words(count, pct);
      end
      // short pause so the next branch hits a full fifo or an open access
      gap = int'($unsigned($random(seed)) % 8);
      repeat (gap) drive_cycle(1'b0, 1'b0, '0);
      line++;
    end

    assert (line > 0) else begin
      errors++;
      $display("no scenarios were read from the data file");
    end

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* bench/instr_mem_model.sv */
//////////////////////////////
// instruction memory model
// req/gnt/rvalid responder with random delays
//////////////////////////////

`timescale 1ns/1ns

`include "fetch_consts.svh"

module instr_mem_model #(
  parameter int Seed = 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_i,
  input  logic [`FETCH_ADDR_W-1:0] addr_i,
  output logic                     gnt_o,
  output logic [`FETCH_DATA_W-1:0] rdata_o,
  output logic                     rvalid_o
);

  integer                   seed;
  // cycles left before the next grant
  logic [1:0]               gnt_wait_q;
  // cycles left before the response
  logic [1:0]               resp_wait_q;
  // one granted access waiting for its response
  logic                     pend_q;
  logic [`FETCH_ADDR_W-1:0] addr_q;

  // word content, address rotated left by a byte with the upper half scrambled
  function automatic logic [`FETCH_DATA_W-1:0] mem_word(input logic [`FETCH_ADDR_W-1:0] a);
    return ((a << 8) | (a >> 24)) ^ 32'hA5A5_0000;
  endfunction

  initial seed = Seed;

  // grant only when nothing is open, or the open access answers this cycle
  assign gnt_o = req_i && (gnt_wait_q == 2'd0) && (!pend_q || rvalid_o);

  always @(posedge clk_i or negedge rst_ni) begin : respond
    int delay;
    if (!rst_ni) begin
      gnt_wait_q  <= 2'd0;
      resp_wait_q <= 2'd0;
      pend_q      <= 1'b0;
      addr_q      <= '0;
      rvalid_o    <= 1'b0;
      rdata_o     <= '0;
    end else begin
      rvalid_o <= 1'b0;
      if (rvalid_o) begin
        pend_q <= 1'b0;
      end else if (pend_q) begin
        if (resp_wait_q == 2'd1) begin
          rvalid_o <= 1'b1;
          rdata_o  <= mem_word(addr_q);
        end
        resp_wait_q <= resp_wait_q - 2'd1;
      end
      // grant delay runs only while a request waits
      if (req_i && !gnt_o && gnt_wait_q != 2'd0) begin
        gnt_wait_q <= gnt_wait_q - 2'd1;
      end
      if (gnt_o) begin
        // 0 to 3 cycles to the next grant, 1 to 3 cycles to this response
        gnt_wait_q  <= 2'($unsigned($random(seed)) % 4);
        delay       = int'($unsigned($random(seed)) % 3) + 1;
        pend_q      <= 1'b1;
        addr_q      <= addr_i;
        resp_wait_q <= 2'(delay - 1);
        if (delay == 1) begin
          rvalid_o <= 1'b1;
          rdata_o  <= mem_word(addr_i);
        end
      end
    end
  end

endmodule

/* design/prefetch_top.sv */
//////////////////////////////
// prefetch unit top
// controller, fetch fifo and output skid stage
//////////////////////////////

`timescale 1ns/1ns

`include "fetch_consts.svh"

module prefetch_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // core control
  input  logic                     req_i,
  input  logic                     branch_i,
  input  logic [`FETCH_ADDR_W-1:0] addr_i,
  // instructions to the core
  input  logic                     ready_i,
  output logic                     valid_o,
  output logic [`FETCH_DATA_W-1:0] rdata_o,
  output logic [`FETCH_ADDR_W-1:0] addr_o,
  // instruction memory
  output logic                     instr_req_o,
  input  logic                     instr_gnt_i,
  output logic [`FETCH_ADDR_W-1:0] instr_addr_o,
  input  logic [`FETCH_DATA_W-1:0] instr_rdata_i,
  input  logic                     instr_rvalid_i,
  output logic                     busy_o
);

  import fetch_pkg::*;

  pf_state_e ctrl_state;

  fetch_stream_if ctrl_to_fifo ();
  fetch_stream_if fifo_to_out ();

  // busy while an access is open or a request is on the bus
  assign busy_o = (ctrl_state != IDLE) || instr_req_o;

  fetch_request_ctrl request_ctrl_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .addr_i        (addr_i),
    .out_o         (ctrl_to_fifo.src),
    .instr_req_o   (instr_req_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_addr_o  (instr_addr_o),
    .instr_rdata_i (instr_rdata_i),
    .instr_rvalid_i(instr_rvalid_i),
    .state_o       (ctrl_state)
  );

  // a branch flushes everything buffered downstream of the controller
  fetch_fifo fetch_fifo_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clear_i(branch_i),
    .in_i   (ctrl_to_fifo.dst),
    .out_o  (fifo_to_out.src)
  );

  fetch_out_skid out_skid_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clear_i(branch_i),
    .in_i   (fifo_to_out.dst),
    .valid_o(valid_o),
    .ready_i(ready_i),
    .rdata_o(rdata_o),
    .addr_o (addr_o)
  );

endmodule

/* design/fetch_out_skid.sv */
//////////////////////////////
// output skid stage
// two registered slots driving the core outputs
//////////////////////////////

`timescale 1ns/1ns

`include "fetch_consts.svh"

module fetch_out_skid (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  fetch_stream_if.dst              in_i,
  // core side
  output logic                     valid_o,
  input  logic                     ready_i,
  output logic [`FETCH_DATA_W-1:0] rdata_o,
  output logic [`FETCH_ADDR_W-1:0] addr_o
);

  import fetch_pkg::*;

  logic         main_valid_q, spare_valid_q;
  fetch_entry_t main_q, spare_q;
  logic         push;
  logic         pop;

  // ready comes from a flop, so no path from ready_i back into the fifo
  assign in_i.ready = !spare_valid_q;
  assign push       = in_i.valid && in_i.ready;
  assign pop        = main_valid_q && ready_i;

  assign valid_o = main_valid_q;
  assign rdata_o = main_q.rdata;
  assign addr_o  = main_q.addr;

  // slot flags
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      main_valid_q  <= 1'b0;
      spare_valid_q <= 1'b0;
    end else if (clear_i) begin
      main_valid_q  <= 1'b0;
      spare_valid_q <= 1'b0;
    end else if (!main_valid_q || pop) begin
      // main slot frees up, refill from spare first
      main_valid_q  <= spare_valid_q || push;
      spare_valid_q <= 1'b0;
    end else if (push) begin
      // core stalled, park the new entry
      spare_valid_q <= 1'b1;
    end
  end

  // payload, held while the core stalls
  always_ff @(posedge clk_i) begin
    if (!main_valid_q || pop) begin
      main_q <= spare_valid_q ? spare_q : '{addr: in_i.addr, rdata: in_i.rdata};
    end else if (push) begin
      spare_q <= '{addr: in_i.addr, rdata: in_i.rdata};
    end
  end

endmodule

/* design/fetch_fifo.sv */
//////////////////////////////
// fetch fifo
// clearable circular buffer of address/data entries
//////////////////////////////

`timescale 1ns/1ns

`include "fetch_consts.svh"

module fetch_fifo (
  input  logic        clk_i,
  input  logic        rst_ni,
  // flush on branch
  input  logic        clear_i,
  // from the request controller
  fetch_stream_if.dst in_i,
  // toward the skid stage
  fetch_stream_if.src out_o
);

  import fetch_pkg::*;

  localparam int unsigned Depth = `FETCH_FIFO_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);
  localparam int unsigned CntW  = $clog2(Depth + 1);

  localparam logic [PtrW-1:0] LastPtr = PtrW'(Depth - 1);
  // room for two entries means the in-flight response plus one more
  localparam logic [CntW-1:0] ReadyMax = CntW'(Depth - 2);

  // storage has no reset, only the pointers and count matter
  fetch_entry_t    mem_q [Depth];
  logic [PtrW-1:0] wptr_q, rptr_q;
  logic [CntW-1:0] count_q;
  logic            wr_en;
  logic            rd_en;

  //////////////////////////////
  // handshake
  //////////////////////////////

  // ready grants permission to issue a request, not to write
  // a response always lands, space was reserved when it was requested
  assign in_i.ready = (count_q <= ReadyMax);
  assign wr_en      = in_i.valid;

  assign out_o.valid = (count_q != '0);
  assign out_o.addr  = mem_q[rptr_q].addr;
  assign out_o.rdata = mem_q[rptr_q].rdata;
  assign rd_en       = out_o.valid && out_o.ready;

  //////////////////////////////
  // storage
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wptr_q] <= '{addr: in_i.addr, rdata: in_i.rdata};
    end
  end

  // pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (clear_i) begin
      // clear wins over a write in the same cycle
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (wr_en) begin
        wptr_q <= (wptr_q == LastPtr) ? '0 : wptr_q + PtrW'(1);
      end
      if (rd_en) begin
        rptr_q <= (rptr_q == LastPtr) ? '0 : rptr_q + PtrW'(1);
      end
      case ({wr_en, rd_en})
        2'b10: count_q <= count_q + CntW'(1);
        2'b01: count_q <= count_q - CntW'(1);
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* design/fetch_request_ctrl.sv */
//////////////////////////////
// fetch request controller
// req/gnt/rvalid fetch FSM with one access in flight
//////////////////////////////

`timescale 1ns/1ns

`include "fetch_consts.svh"

module fetch_request_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // core side control
  input  logic                     req_i,
  input  logic                     branch_i,
  input  logic [`FETCH_ADDR_W-1:0] addr_i,
  // fetched words toward the fifo
  fetch_stream_if.src              out_o,
  // instruction memory
  output logic                     instr_req_o,
  input  logic                     instr_gnt_i,
  output logic [`FETCH_ADDR_W-1:0] instr_addr_o,
  input  logic [`FETCH_DATA_W-1:0] instr_rdata_i,
  input  logic                     instr_rvalid_i,
  // state for the busy flag
  output fetch_pkg::pf_state_e     state_o
);

  import fetch_pkg::*;

  pf_state_e                state_q, state_d;
  // address of the access in flight, or of the last one
  logic [`FETCH_ADDR_W-1:0] addr_q;
  logic [`FETCH_ADDR_W-1:0] next_addr;
  logic                     addr_we;
  logic                     push;

  //////////////////////////////
  // sequential address
  //////////////////////////////

  // word aligned successor, low bits of a branch target are dropped here
  assign next_addr = {addr_q[`FETCH_ADDR_W-1:2], 2'b00} + `FETCH_ADDR_W'(4);

  // response goes to the fifo tagged with its own address
  assign out_o.valid = push;
  assign out_o.addr  = addr_q;
  assign out_o.rdata = instr_rdata_i;

  assign state_o = state_q;

  //////////////////////////////
  // fetch FSM
  //////////////////////////////

  always_comb begin
    state_d      = state_q;
    instr_req_o  = 1'b0;
    instr_addr_o = next_addr;
    push         = 1'b0;
    addr_we      = 1'b0;

    case (state_q)
      // nothing in flight
      IDLE: begin
        if (branch_i) begin
          instr_addr_o = addr_i;
        end
        // fifo ready means room for this response, a branch empties it anyway
        if (req_i && (out_o.ready || branch_i)) begin
          instr_req_o = 1'b1;
          addr_we     = 1'b1;
          state_d     = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end

      // request out, grant pending
      WAIT_GNT: begin
        instr_req_o  = 1'b1;
        instr_addr_o = addr_q;
        // not granted yet, so the pending request is simply retargeted
        if (branch_i) begin
          instr_addr_o = addr_i;
          addr_we      = 1'b1;
        end
        state_d = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
      end

      // granted, response pending
      WAIT_RVALID: begin
        if (branch_i) begin
          instr_addr_o = addr_i;
        end
        if (req_i && (out_o.ready || branch_i)) begin
          if (instr_rvalid_i) begin
            // store the word and chain the next request in the same cycle
            // on a branch the fifo clear drops the stored word
            instr_req_o = 1'b1;
            push        = 1'b1;
            addr_we     = 1'b1;
            state_d     = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
          end else if (branch_i) begin
            // old access still open, remember the target and wait it out
            addr_we = 1'b1;
            state_d = WAIT_ABORTED;
          end
        end else if (instr_rvalid_i) begin
          // last word, no follow-up request
          push    = 1'b1;
          state_d = IDLE;
        end
      end

      // stale response pending, addr_q already holds the branch target
      WAIT_ABORTED: begin
        instr_addr_o = addr_q;
        if (branch_i) begin
          instr_addr_o = addr_i;
          addr_we      = 1'b1;
        end
        // stale word is never pushed
        if (instr_rvalid_i) begin
          instr_req_o = 1'b1;
          state_d     = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (addr_we) begin
        addr_q <= instr_addr_o;
      end
    end
  end

endmodule

/* design/fetch_stream_if.sv */
//////////////////////////////
// fetch stream interface
// address/data stream with valid/ready handshake
//////////////////////////////

`timescale 1ns/1ns

`include "fetch_consts.svh"

interface fetch_stream_if;

  // handshake
  logic                     valid;
  logic                     ready;
  // payload, stable while valid is high and ready low
  logic [`FETCH_ADDR_W-1:0] addr;
  logic [`FETCH_DATA_W-1:0] rdata;

  // producer side
  modport src (output valid, output addr, output rdata, input ready);

  // consumer side
  modport dst (input valid, input addr, input rdata, output ready);

endinterface

/* design/fetch_pkg.sv */
//////////////////////////////
// prefetch types
// controller state encoding and buffered instruction entry
//////////////////////////////

`include "fetch_consts.svh"

package fetch_pkg;

  // request controller states
  // WAIT_ABORTED drops the stale response of an access cut off by a branch
  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED
  } pf_state_e;

  // one buffered instruction with the address it came from
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] addr;
    logic [`FETCH_DATA_W-1:0] rdata;
  } fetch_entry_t;

endpackage

/* design/fetch_consts.svh */
//////////////////////////////
// prefetch constants
// bus widths and fifo sizing for the fetch path
//////////////////////////////

`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// instruction address and word width
`define FETCH_ADDR_W 32
`define FETCH_DATA_W 32
// fetch fifo entries, at least 2 for the early ready rule
`define FETCH_FIFO_DEPTH 3

`endif
